//--- rtl/mmio_pkg.sv
/*
  Address map and response codes for the MMIO subsystem.
  Both windows must stay aligned to their own size; the SRAM window is
  SRAM_WORDS * 4 bytes starting at SRAM_BASE.
*/
package mmio_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // console UART, 8-byte window
    localparam logic [ADDR_W-1:0] UART_BASE = 32'ha000_03f8;
    localparam int UART_SIZE = 8;

    // 1 KiB of word-wide SRAM
    localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;
    localparam int SRAM_WORDS = 256;
    localparam int SRAM_AW = $clog2(SRAM_WORDS);

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY = 2'b00;
    // read of a write-only device
    localparam resp_t RESP_NOREAD = 2'b01;
    localparam resp_t RESP_DECERR = 2'b11;

endpackage

//--- rtl/axil_if.sv
/*
  AXI-Lite bundle, no protection or cache signals.
  Only one outstanding transaction is expected on any instance.
*/
`timescale 1ns/1ps

interface axil_if;
    import mmio_pkg::*;

    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wvalid;
    logic              wready;
    resp_t             bresp;
    logic              bvalid;
    logic              bready;
    logic [ADDR_W-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [DATA_W-1:0] rdata;
    resp_t             rresp;
    logic              rvalid;
    logic              rready;

    modport master (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    modport slave (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

endinterface

//--- rtl/axil_xbar.sv
/*
  One-transaction crossbar for the UART and SRAM windows of mmio_pkg.
  Everything else is answered here with DECERR and zero data.
  Write address and data must arrive together; reads win over writes.
*/
`timescale 1ns/1ps

module axil_xbar (
    input logic    clk,
    input logic    reset,
    axil_if.slave  up,
    axil_if.master uart,
    axil_if.master sram
);
    import mmio_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_ACCEPT, S_FWD, S_RESP} state_t;
    typedef enum logic [1:0] {TGT_ERR, TGT_UART, TGT_SRAM} tgt_t;

    state_t            state;
    tgt_t              tgt;
    tgt_t              dec_tgt;
    logic              is_read;
    logic              fwd_valid;
    logic              err_valid;
    logic              slave_hs;
    logic              up_hs;
    logic [ADDR_W-1:0] dec_addr;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic [STRB_W-1:0] req_wstrb;

    function automatic tgt_t decode(input logic [ADDR_W-1:0] addr);
        // an offset below the base wraps to a large value
        if ((addr - UART_BASE) < ADDR_W'(UART_SIZE)) begin
            return TGT_UART;
        end
        if ((addr - SRAM_BASE) < ADDR_W'(SRAM_WORDS * STRB_W)) begin
            return TGT_SRAM;
        end
        return TGT_ERR;
    endfunction

    assign dec_addr = is_read ? up.araddr : up.awaddr;
    assign dec_tgt  = decode(dec_addr);

    // same request payload to both slaves
    assign uart.awaddr  = req_addr;
    assign uart.araddr  = req_addr;
    assign uart.wdata   = req_wdata;
    assign uart.wstrb   = req_wstrb;
    assign uart.arvalid = fwd_valid && is_read && (tgt == TGT_UART);
    assign uart.awvalid = fwd_valid && !is_read && (tgt == TGT_UART);
    assign uart.wvalid  = uart.awvalid;

    assign sram.awaddr  = req_addr;
    assign sram.araddr  = req_addr;
    assign sram.wdata   = req_wdata;
    assign sram.wstrb   = req_wstrb;
    assign sram.arvalid = fwd_valid && is_read && (tgt == TGT_SRAM);
    assign sram.awvalid = fwd_valid && !is_read && (tgt == TGT_SRAM);
    assign sram.wvalid  = sram.awvalid;

    assign slave_hs = (uart.arvalid && uart.arready) || (uart.awvalid && uart.awready)
                   || (sram.arvalid && sram.arready) || (sram.awvalid && sram.awready);
    assign up_hs = (up.rvalid && up.rready) || (up.bvalid && up.bready);

    // slave holds its response until the outside takes it
    always_comb begin
        up.rvalid   = 1'b0;
        up.rdata    = '0;
        up.rresp    = RESP_OKAY;
        up.bvalid   = 1'b0;
        up.bresp    = RESP_OKAY;
        uart.rready = 1'b0;
        uart.bready = 1'b0;
        sram.rready = 1'b0;
        sram.bready = 1'b0;
        if (state == S_RESP) begin
            case (tgt)
                TGT_UART: begin
                    up.rvalid   = uart.rvalid;
                    up.rdata    = uart.rdata;
                    up.rresp    = uart.rresp;
                    up.bvalid   = uart.bvalid;
                    up.bresp    = uart.bresp;
                    uart.rready = up.rready;
                    uart.bready = up.bready;
                end
                TGT_SRAM: begin
                    up.rvalid   = sram.rvalid;
                    up.rdata    = sram.rdata;
                    up.rresp    = sram.rresp;
                    up.bvalid   = sram.bvalid;
                    up.bresp    = sram.bresp;
                    sram.rready = up.rready;
                    sram.bready = up.bready;
                end
                default: begin
                    up.rvalid = err_valid && is_read;
                    up.bvalid = err_valid && !is_read;
                    up.rresp  = RESP_DECERR;
                    up.bresp  = RESP_DECERR;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            tgt        <= TGT_ERR;
            is_read    <= 1'b0;
            fwd_valid  <= 1'b0;
            err_valid  <= 1'b0;
            up.arready <= 1'b0;
            up.awready <= 1'b0;
            up.wready  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (up.arvalid) begin
                        up.arready <= 1'b1;
                        is_read    <= 1'b1;
                        state      <= S_ACCEPT;
                    end else if (up.awvalid && up.wvalid) begin
                        up.awready <= 1'b1;
                        up.wready  <= 1'b1;
                        is_read    <= 1'b0;
                        state      <= S_ACCEPT;
                    end
                end
                // handshake with the outside happens in this cycle
                S_ACCEPT: begin
                    up.arready <= 1'b0;
                    up.awready <= 1'b0;
                    up.wready  <= 1'b0;
                    tgt        <= dec_tgt;
                    if (dec_tgt == TGT_ERR) begin
                        err_valid <= 1'b1;
                        state     <= S_RESP;
                    end else begin
                        fwd_valid <= 1'b1;
                        state     <= S_FWD;
                    end
                end
                S_FWD: begin
                    if (slave_hs) begin
                        fwd_valid <= 1'b0;
                        state     <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (up_hs) begin
                        err_valid <= 1'b0;
                        state     <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_ACCEPT) begin
            req_addr  <= dec_addr;
            req_wdata <= up.wdata;
            req_wstrb <= up.wstrb;
        end
    end

    a_one_resp: assert property (@(posedge clk) disable iff (reset)
        !(up.rvalid && up.bvalid))
        else $error("read and write responses high together");

    a_one_slave: assert property (@(posedge clk) disable iff (reset)
        $onehot0({uart.arvalid || uart.awvalid || uart.rvalid || uart.bvalid,
                  sram.arvalid || sram.awvalid || sram.rvalid || sram.bvalid}))
        else $error("valid active on more than one slave channel");

endmodule

//--- rtl/uart_axil.sv
/*
  Write-only console: byte 0 of each write goes out on tx_valid/tx_data
  when wstrb[0] is set. Reads are answered with RESP_NOREAD and zero.
  The console has no back-pressure.
*/
`timescale 1ns/1ps

module uart_axil (
    input logic        clk,
    input logic        reset,
    axil_if.slave      bus,
    output logic       tx_valid,
    output logic [7:0] tx_data
);
    import mmio_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ_ADDR,
        S_READ_DATA,
        S_WRITE_ADDR,
        S_WRITE_DATA,
        S_WRITE_RESP
    } state_t;

    state_t state;
    logic   rd_hs;
    logic   wr_hs;

    assign rd_hs = bus.arvalid && bus.arready;
    assign wr_hs = bus.awvalid && bus.awready && bus.wvalid && bus.wready;

    // fixed answers
    assign bus.rdata = '0;
    assign bus.rresp = RESP_NOREAD;
    assign bus.bresp = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= S_IDLE;
            bus.arready <= 1'b0;
            bus.awready <= 1'b0;
            bus.wready  <= 1'b0;
            bus.rvalid  <= 1'b0;
            bus.bvalid  <= 1'b0;
            tx_valid    <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (bus.arvalid) begin
                        bus.arready <= 1'b1;
                        state       <= S_READ_ADDR;
                    end else if (bus.awvalid && bus.wvalid) begin
                        bus.awready <= 1'b1;
                        bus.wready  <= 1'b1;
                        state       <= S_WRITE_ADDR;
                    end
                end
                S_READ_ADDR: begin
                    bus.arready <= 1'b0;
                    if (rd_hs) begin
                        bus.rvalid <= 1'b1;
                        state      <= S_READ_DATA;
                    end else begin
                        state <= S_IDLE;
                    end
                end
                S_READ_DATA: begin
                    if (bus.rready) begin
                        bus.rvalid <= 1'b0;
                        state      <= S_IDLE;
                    end
                end
                S_WRITE_ADDR: begin
                    bus.awready <= 1'b0;
                    bus.wready  <= 1'b0;
                    if (wr_hs) begin
                        bus.bvalid <= 1'b1;
                        tx_valid   <= bus.wstrb[0];
                        state      <= S_WRITE_DATA;
                    end else begin
                        state <= S_IDLE;
                    end
                end
                // first response cycle, console strobe is up here
                S_WRITE_DATA: begin
                    tx_valid <= 1'b0;
                    if (bus.bready) begin
                        bus.bvalid <= 1'b0;
                        state      <= S_IDLE;
                    end else begin
                        state <= S_WRITE_RESP;
                    end
                end
                S_WRITE_RESP: begin
                    if (bus.bready) begin
                        bus.bvalid <= 1'b0;
                        state      <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs && bus.wstrb[0]) begin
            tx_data <= bus.wdata[7:0];
        end
    end

    a_tx_pulse: assert property (@(posedge clk) disable iff (reset)
        tx_valid |=> !tx_valid)
        else $error("console strobe longer than one cycle");

endmodule

//--- rtl/sram_axil.sv
/*
  Single-port word SRAM, no reset of contents.
  Word index is taken from address bits SRAM_AW+1 down to 2; upper
  address bits are ignored, decoding is left to the crossbar.
*/
`timescale 1ns/1ps

module sram_axil (
    input logic   clk,
    input logic   reset,
    axil_if.slave bus
);
    import mmio_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ_ADDR,
        S_READ_DATA,
        S_WRITE_ADDR,
        S_WRITE_RESP
    } state_t;

    state_t             state;
    logic               rd_hs;
    logic               wr_hs;
    logic [SRAM_AW-1:0] rd_idx;
    logic [SRAM_AW-1:0] wr_idx;
    logic [DATA_W-1:0]  mem [SRAM_WORDS];

    assign rd_hs  = bus.arvalid && bus.arready;
    assign wr_hs  = bus.awvalid && bus.awready && bus.wvalid && bus.wready;
    assign rd_idx = bus.araddr[SRAM_AW+1:2];
    assign wr_idx = bus.awaddr[SRAM_AW+1:2];

    assign bus.rresp = RESP_OKAY;
    assign bus.bresp = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= S_IDLE;
            bus.arready <= 1'b0;
            bus.awready <= 1'b0;
            bus.wready  <= 1'b0;
            bus.rvalid  <= 1'b0;
            bus.bvalid  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (bus.arvalid) begin
                        bus.arready <= 1'b1;
                        state       <= S_READ_ADDR;
                    end else if (bus.awvalid && bus.wvalid) begin
                        bus.awready <= 1'b1;
                        bus.wready  <= 1'b1;
                        state       <= S_WRITE_ADDR;
                    end
                end
                S_READ_ADDR: begin
                    bus.arready <= 1'b0;
                    bus.rvalid  <= rd_hs;
                    state       <= rd_hs ? S_READ_DATA : S_IDLE;
                end
                S_READ_DATA: begin
                    if (bus.rready) begin
                        bus.rvalid <= 1'b0;
                        state      <= S_IDLE;
                    end
                end
                S_WRITE_ADDR: begin
                    bus.awready <= 1'b0;
                    bus.wready  <= 1'b0;
                    bus.bvalid  <= wr_hs;
                    state       <= wr_hs ? S_WRITE_RESP : S_IDLE;
                end
                S_WRITE_RESP: begin
                    if (bus.bready) begin
                        bus.bvalid <= 1'b0;
                        state      <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // byte lanes merged under wstrb
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (bus.wstrb[i]) begin
                    mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
        if (rd_hs) begin
            bus.rdata <= mem[rd_idx];
        end
    end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        bus.rvalid && !bus.rready |=> bus.rvalid)
        else $error("rvalid dropped before rready");

    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        bus.bvalid && !bus.bready |=> bus.bvalid)
        else $error("bvalid dropped before bready");

endmodule

//--- rtl/mmio_subsystem.sv
/*
  AXI-Lite slave port in front of the crossbar, UART and SRAM.
  One transaction at a time; aw and w must be presented together.
*/
`timescale 1ns/1ps

module mmio_subsystem (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [mmio_pkg::ADDR_W-1:0] awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [mmio_pkg::DATA_W-1:0] wdata,
    input  logic [mmio_pkg::STRB_W-1:0] wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output mmio_pkg::resp_t             bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [mmio_pkg::ADDR_W-1:0] araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [mmio_pkg::DATA_W-1:0] rdata,
    output mmio_pkg::resp_t             rresp,
    output logic                        rvalid,
    input  logic                        rready,
    output logic                        uart_tx_valid,
    output logic [7:0]                  uart_tx_data
);

    axil_if up_bus ();
    axil_if uart_bus ();
    axil_if sram_bus ();

    assign up_bus.awaddr  = awaddr;
    assign up_bus.awvalid = awvalid;
    assign up_bus.wdata   = wdata;
    assign up_bus.wstrb   = wstrb;
    assign up_bus.wvalid  = wvalid;
    assign up_bus.bready  = bready;
    assign up_bus.araddr  = araddr;
    assign up_bus.arvalid = arvalid;
    assign up_bus.rready  = rready;

    assign awready = up_bus.awready;
    assign wready  = up_bus.wready;
    assign bresp   = up_bus.bresp;
    assign bvalid  = up_bus.bvalid;
    assign arready = up_bus.arready;
    assign rdata   = up_bus.rdata;
    assign rresp   = up_bus.rresp;
    assign rvalid  = up_bus.rvalid;

    axil_xbar i_axil_xbar (
        .clk   (clk),
        .reset (reset),
        .up    (up_bus.slave),
        .uart  (uart_bus.master),
        .sram  (sram_bus.master)
    );

    uart_axil i_uart_axil (
        .clk      (clk),
        .reset    (reset),
        .bus      (uart_bus.slave),
        .tx_valid (uart_tx_valid),
        .tx_data  (uart_tx_data)
    );

    sram_axil i_sram_axil (
        .clk   (clk),
        .reset (reset),
        .bus   (sram_bus.slave)
    );

endmodule

//--- tb/tb_clock.sv
/*
  Free-running 10 ns clock. Reset is high for the first 10 cycles
  and is released on a falling edge.
*/
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- tb/tb_mmio_subsystem.sv
/*
  Table-driven testbench for mmio_subsystem. One access at a time, inputs
  change on the falling edge, response ready is held off 0 to 5 cycles.
  Expected words assume the table order, since SRAM contents carry over.
*/
`timescale 1ns/1ps

module tb_mmio_subsystem;
    import mmio_pkg::*;

    localparam int RESET_CYCLES      = 10;
    localparam int CYCLES_PER_ACCESS = 64;
    localparam int CLK_PERIOD_NS     = 10;
    localparam int MAX_DELAY         = 5;

    typedef struct packed {
        logic              is_write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
        resp_t             resp;
        logic [DATA_W-1:0] rdata;
        logic              has_tx;
        logic [7:0]        tx;
    } access_t;

    logic              clk;
    logic              reset;
    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wvalid;
    logic              wready;
    resp_t             bresp;
    logic              bvalid;
    logic              bready;
    logic [ADDR_W-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [DATA_W-1:0] rdata;
    resp_t             rresp;
    logic              rvalid;
    logic              rready;
    logic              uart_tx_valid;
    logic [7:0]        uart_tx_data;

    access_t    accesses[$];
    logic [7:0] tx_seen[$];
    int         checks = 0;
    int         errors = 0;
    bit         table_built = 1'b0;

    tb_clock i_tb_clock (
        .clk   (clk),
        .reset (reset)
    );

    mmio_subsystem i_mmio_subsystem (
        .clk           (clk),
        .reset         (reset),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .uart_tx_valid (uart_tx_valid),
        .uart_tx_data  (uart_tx_data)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic add_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb, input resp_t resp,
                             input logic has_tx, input logic [7:0] tx);
        accesses.push_back('{1'b1, addr, data, strb, resp, '0, has_tx, tx});
    endtask

    task automatic add_read(input logic [ADDR_W-1:0] addr, input resp_t resp,
                            input logic [DATA_W-1:0] data);
        accesses.push_back('{1'b0, addr, '0, '0, resp, data, 1'b0, 8'h00});
    endtask

    task automatic build_table();
        // sram, full words then merged byte lanes
        add_write(32'h8000_0000, 32'h1122_3344, 4'hf, RESP_OKAY, 1'b0, 8'h00);
        add_write(32'h8000_0004, 32'haabb_ccdd, 4'hf, RESP_OKAY, 1'b0, 8'h00);
        add_write(32'h8000_0000, 32'h5566_7788, 4'h5, RESP_OKAY, 1'b0, 8'h00);
        add_read(32'h8000_0000, RESP_OKAY, 32'h1166_3388);
        add_write(32'h8000_0004, 32'h0000_ee00, 4'h2, RESP_OKAY, 1'b0, 8'h00);
        add_read(32'h8000_0004, RESP_OKAY, 32'haabb_eedd);
        add_write(32'h8000_03fc, 32'hcafe_f00d, 4'hf, RESP_OKAY, 1'b0, 8'h00);
        add_write(32'h8000_03fc, 32'h1234_5678, 4'hc, RESP_OKAY, 1'b0, 8'h00);
        add_read(32'h8000_03fc, RESP_OKAY, 32'h1234_f00d);
        // console
        add_write(32'ha000_03f8, 32'h0000_0048, 4'h1, RESP_OKAY, 1'b1, 8'h48);
        add_write(32'ha000_03f8, 32'h0000_0069, 4'he, RESP_OKAY, 1'b0, 8'h00);
        add_write(32'ha000_03fc, 32'h0000_0121, 4'hf, RESP_OKAY, 1'b1, 8'h21);
        add_read(32'ha000_03f8, RESP_NOREAD, 32'h0000_0000);
        // holes around both windows
        add_read(32'h0000_1000, RESP_DECERR, 32'h0000_0000);
        add_write(32'h8000_0400, 32'hffff_ffff, 4'hf, RESP_DECERR, 1'b0, 8'h00);
        add_write(32'ha000_0400, 32'h0000_0041, 4'hf, RESP_DECERR, 1'b0, 8'h00);
        add_read(32'h8000_0400, RESP_DECERR, 32'h0000_0000);
        add_read(32'ha000_03f0, RESP_DECERR, 32'h0000_0000);
        // sram untouched by the rejected writes
        add_read(32'h8000_0000, RESP_OKAY, 32'h1166_3388);
        add_read(32'h8000_03fc, RESP_OKAY, 32'h1234_f00d);
    endtask

    task automatic check_idle_outputs();
        check_value("arready", 32'd0, 32'(arready));
        check_value("awready", 32'd0, 32'(awready));
        check_value("wready", 32'd0, 32'(wready));
        check_value("rvalid", 32'd0, 32'(rvalid));
        check_value("bvalid", 32'd0, 32'(bvalid));
        check_value("uart_tx_valid", 32'd0, 32'(uart_tx_valid));
    endtask

    task automatic run_access(input access_t acc);
        logic [DATA_W-1:0] held_data;
        resp_t             held_resp;
        int                delay;
        tx_seen.delete();
        delay = int'($urandom % (MAX_DELAY + 1));
        if (acc.is_write) begin
            awaddr  = acc.addr;
            wdata   = acc.wdata;
            wstrb   = acc.wstrb;
            awvalid = 1'b1;
            wvalid  = 1'b1;
            do @(negedge clk); while (!(awready && wready));
            // handshake on the next rising edge
            @(negedge clk);
            awvalid = 1'b0;
            wvalid  = 1'b0;
            while (!bvalid) @(negedge clk);
            held_resp = bresp;
            check_value("bresp", 32'(acc.resp), 32'(bresp));
            repeat (delay) begin
                @(negedge clk);
                check_value("bvalid", 32'd1, 32'(bvalid));
                check_value("bresp", 32'(held_resp), 32'(bresp));
            end
            bready = 1'b1;
            @(negedge clk);
            bready = 1'b0;
            check_value("bvalid", 32'd0, 32'(bvalid));
        end else begin
            araddr  = acc.addr;
            arvalid = 1'b1;
            do @(negedge clk); while (!arready);
            @(negedge clk);
            arvalid = 1'b0;
            while (!rvalid) @(negedge clk);
            held_data = rdata;
            held_resp = rresp;
            check_value("rresp", 32'(acc.resp), 32'(rresp));
            check_value("rdata", acc.rdata, rdata);
            repeat (delay) begin
                @(negedge clk);
                check_value("rvalid", 32'd1, 32'(rvalid));
                check_value("rdata", held_data, rdata);
                check_value("rresp", 32'(held_resp), 32'(rresp));
            end
            rready = 1'b1;
            @(negedge clk);
            rready = 1'b0;
            check_value("rvalid", 32'd0, 32'(rvalid));
        end
        check_value("console strobes", 32'(acc.has_tx), tx_seen.size());
        if (acc.has_tx && tx_seen.size() > 0) begin
            check_value("uart_tx_data", 32'(acc.tx), 32'(tx_seen[0]));
        end
    endtask

    // console strobe is a full cycle wide
    always @(negedge clk) begin
        if (!reset && uart_tx_valid) begin
            tx_seen.push_back(uart_tx_data);
        end
    end

    initial begin
        void'($urandom(24896));
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        build_table();
        table_built = 1'b1;
        wait (reset == 1'b0);
        @(negedge clk);
        check_idle_outputs();
        foreach (accesses[i]) begin
            run_access(accesses[i]);
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (table_built);
        #((RESET_CYCLES + accesses.size() * CYCLES_PER_ACCESS) * CLK_PERIOD_NS);
        $display("Timeout: the DUT stopped answering before the access table was done");
        $display("Summary: %0d checks, %0d errors", checks, errors);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- compile.f
rtl/mmio_pkg.sv
rtl/axil_if.sv
rtl/axil_xbar.sv
rtl/uart_axil.sv
rtl/sram_axil.sv
rtl/mmio_subsystem.sv
tb/tb_clock.sv
tb/tb_mmio_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and check for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_mmio_subsystem \
    -f compile.f \
    -o tb_mmio_subsystem

output="$(./obj_dir/tb_mmio_subsystem)"
echo "$output"

if grep -qx "All checks passed" <<< "$output"; then
    exit 0
else
    exit 1
fi
